// ==== src/axil_mem_pkg.sv ====
/* Shared AXI4-Lite types, response codes and address map for the memory subsystem.
   Single master, no bursts; prot fields are carried but never checked. */
package axil_mem_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // RAM window, 256 words of 32 bits
    localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h0000_0000;
    localparam int                RAM_WORDS = 256;
    localparam int                RAM_IDX_W = $clog2(RAM_WORDS);
    localparam logic [ADDR_W-1:0] RAM_BYTES = ADDR_W'(RAM_WORDS * STRB_W);

    // Register block, two words
    localparam logic [ADDR_W-1:0] REG_BASE = 32'h1000_0000;
    localparam logic [ADDR_W-1:0] LED_OFFS = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] ID_OFFS  = 32'h0000_0004;
    localparam int                LED_W    = 8;
    localparam logic [DATA_W-1:0] ID_VALUE = 32'h4158_4C31; // ASCII "AXL1"

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // Master to slave
    typedef struct packed {
        logic [ADDR_W-1:0] aw_addr;
        logic [2:0]        aw_prot;
        logic              aw_valid;
        logic [DATA_W-1:0] w_data;
        logic [STRB_W-1:0] w_strb;
        logic              w_valid;
        logic              b_ready;
        logic [ADDR_W-1:0] ar_addr;
        logic [2:0]        ar_prot;
        logic              ar_valid;
        logic              r_ready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic              aw_ready;
        logic              w_ready;
        logic              b_valid;
        logic [1:0]        b_resp;
        logic              ar_ready;
        logic              r_valid;
        logic [DATA_W-1:0] r_data;
        logic [1:0]        r_resp;
    } axil_rsp_t;

endpackage

// ==== src/axil_ram.sv ====
/* Byte-strobed word RAM behind an AXI-Lite slave. Contents are undefined after
   power-up and survive reset. AW and W must arrive together; responses are always OKAY. */
`timescale 1ns/10ps

module axil_ram
    import axil_mem_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  axil_req_t req,
    output axil_rsp_t rsp
);

    logic [DATA_W-1:0]    mem [RAM_WORDS];
    logic [RAM_IDX_W-1:0] wr_idx;
    logic [RAM_IDX_W-1:0] rd_idx;
    logic                 wr_take;   // AW and W accepted this cycle
    logic                 rd_take;   // AR accepted this cycle
    logic                 b_done;
    logic                 r_done;
    logic                 b_valid_q;
    logic                 r_valid_q;
    logic [DATA_W-1:0]    r_data_q;

    // Word index, byte offset bits dropped
    assign wr_idx = req.aw_addr[RAM_IDX_W+1:2];
    assign rd_idx = req.ar_addr[RAM_IDX_W+1:2];

    // One write outstanding; a pending B blocks the next address
    assign wr_take = req.aw_valid && req.w_valid && !b_valid_q;
    assign rd_take = req.ar_valid && !r_valid_q;

    assign b_done = b_valid_q && req.b_ready;
    assign r_done = r_valid_q && req.r_ready;

    // Storage with per-byte write enable
    always_ff @(posedge aclk) begin
        if (wr_take) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (req.w_strb[b]) begin
                    mem[wr_idx][b*8 +: 8] <= req.w_data[b*8 +: 8];
                end
            end
        end
    end

    // Read data only loads on a new AR, so it holds under back-pressure
    always_ff @(posedge aclk) begin
        if (rd_take) begin
            r_data_q <= mem[rd_idx];
        end
    end

    // Write response channel
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            b_valid_q <= 1'b0;
        end else if (wr_take) begin
            b_valid_q <= 1'b1;
        end else if (b_done) begin
            b_valid_q <= 1'b0;
        end
    end

    // Read response channel
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            r_valid_q <= 1'b0;
        end else if (rd_take) begin
            r_valid_q <= 1'b1;
        end else if (r_done) begin
            r_valid_q <= 1'b0;
        end
    end

    always_comb begin
        rsp          = '0;
        rsp.aw_ready = wr_take;   // Both readies rise together
        rsp.w_ready  = wr_take;
        rsp.b_valid  = b_valid_q;
        rsp.b_resp   = RESP_OKAY;
        rsp.ar_ready = rd_take;
        rsp.r_valid  = r_valid_q;
        rsp.r_data   = r_data_q;
        rsp.r_resp   = RESP_OKAY;
    end

endmodule

// ==== src/axil_addr_decoder.sv ====
/* Splits one AXI-Lite slave port between the RAM and the register block with no added
   latency. One transaction per direction in flight; unmapped addresses get DECERR. */
`timescale 1ns/10ps

module axil_addr_decoder
    import axil_mem_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  axil_req_t s_req,
    output axil_rsp_t s_rsp,
    output axil_req_t ram_req,
    input  axil_rsp_t ram_rsp,
    output axil_req_t reg_req,
    input  axil_rsp_t reg_rsp
);

    logic aw_hit_ram;
    logic aw_hit_reg;
    logic ar_hit_ram;
    logic ar_hit_reg;
    logic wr_own_ram;   // Owner of the pending B response
    logic wr_own_reg;
    logic wr_own_err;
    logic rd_own_ram;   // Owner of the pending R response
    logic rd_own_reg;
    logic rd_own_err;
    logic wr_busy;
    logic rd_busy;
    logic wr_fire;
    logic rd_fire;
    logic b_done;
    logic r_done;

    function automatic logic in_ram(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] offs;
        offs = addr - RAM_BASE;   // Wraps below the base, so one compare covers both ends
        return offs < RAM_BYTES;
    endfunction

    function automatic logic in_regs(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] word;
        word = {addr[ADDR_W-1:2], 2'b00};
        return (word == REG_BASE + LED_OFFS) || (word == REG_BASE + ID_OFFS);
    endfunction

    assign aw_hit_ram = in_ram(s_req.aw_addr);
    assign aw_hit_reg = in_regs(s_req.aw_addr);
    assign ar_hit_ram = in_ram(s_req.ar_addr);
    assign ar_hit_reg = in_regs(s_req.ar_addr);

    assign wr_busy = wr_own_ram || wr_own_reg || wr_own_err;
    assign rd_busy = rd_own_ram || rd_own_reg || rd_own_err;

    // Valid goes only to the addressed target, ready only to the owner
    always_comb begin
        ram_req          = s_req;
        reg_req          = s_req;
        ram_req.aw_valid = s_req.aw_valid && aw_hit_ram && !wr_busy;
        ram_req.w_valid  = s_req.w_valid && aw_hit_ram && !wr_busy;
        reg_req.aw_valid = s_req.aw_valid && aw_hit_reg && !wr_busy;
        reg_req.w_valid  = s_req.w_valid && aw_hit_reg && !wr_busy;
        ram_req.b_ready  = s_req.b_ready && wr_own_ram;
        reg_req.b_ready  = s_req.b_ready && wr_own_reg;
        ram_req.ar_valid = s_req.ar_valid && ar_hit_ram && !rd_busy;
        reg_req.ar_valid = s_req.ar_valid && ar_hit_reg && !rd_busy;
        ram_req.r_ready  = s_req.r_ready && rd_own_ram;
        reg_req.r_ready  = s_req.r_ready && rd_own_reg;
    end

    always_comb begin
        s_rsp = '0;
        if (!wr_busy) begin
            if (aw_hit_ram) begin
                s_rsp.aw_ready = ram_rsp.aw_ready;
                s_rsp.w_ready  = ram_rsp.w_ready;
            end else if (aw_hit_reg) begin
                s_rsp.aw_ready = reg_rsp.aw_ready;
                s_rsp.w_ready  = reg_rsp.w_ready;
            end else begin   // Unmapped, take it here
                s_rsp.aw_ready = s_req.aw_valid && s_req.w_valid;
                s_rsp.w_ready  = s_req.aw_valid && s_req.w_valid;
            end
        end
        if (!rd_busy) begin
            if (ar_hit_ram)      s_rsp.ar_ready = ram_rsp.ar_ready;
            else if (ar_hit_reg) s_rsp.ar_ready = reg_rsp.ar_ready;
            else                 s_rsp.ar_ready = s_req.ar_valid;
        end

        // Response routing by latched owner
        if (wr_own_ram) begin
            s_rsp.b_valid = ram_rsp.b_valid;
            s_rsp.b_resp  = ram_rsp.b_resp;
        end else if (wr_own_reg) begin
            s_rsp.b_valid = reg_rsp.b_valid;
            s_rsp.b_resp  = reg_rsp.b_resp;
        end else if (wr_own_err) begin
            s_rsp.b_valid = 1'b1;
            s_rsp.b_resp  = RESP_DECERR;
        end
        if (rd_own_ram) begin
            s_rsp.r_valid = ram_rsp.r_valid;
            s_rsp.r_data  = ram_rsp.r_data;
            s_rsp.r_resp  = ram_rsp.r_resp;
        end else if (rd_own_reg) begin
            s_rsp.r_valid = reg_rsp.r_valid;
            s_rsp.r_data  = reg_rsp.r_data;
            s_rsp.r_resp  = reg_rsp.r_resp;
        end else if (rd_own_err) begin
            s_rsp.r_valid = 1'b1;   // Data stays zero
            s_rsp.r_resp  = RESP_DECERR;
        end
    end

    assign wr_fire = s_req.aw_valid && s_rsp.aw_ready;
    assign rd_fire = s_req.ar_valid && s_rsp.ar_ready;
    assign b_done  = s_rsp.b_valid && s_req.b_ready;
    assign r_done  = s_rsp.r_valid && s_req.r_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_own_ram <= 1'b0;
            wr_own_reg <= 1'b0;
            wr_own_err <= 1'b0;
        end else if (wr_fire) begin
            wr_own_ram <= aw_hit_ram;
            wr_own_reg <= aw_hit_reg;
            wr_own_err <= !aw_hit_ram && !aw_hit_reg;
        end else if (b_done) begin
            wr_own_ram <= 1'b0;
            wr_own_reg <= 1'b0;
            wr_own_err <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_own_ram <= 1'b0;
            rd_own_reg <= 1'b0;
            rd_own_err <= 1'b0;
        end else if (rd_fire) begin
            rd_own_ram <= ar_hit_ram;
            rd_own_reg <= ar_hit_reg;
            rd_own_err <= !ar_hit_ram && !ar_hit_reg;
        end else if (r_done) begin
            rd_own_ram <= 1'b0;
            rd_own_reg <= 1'b0;
            rd_own_err <= 1'b0;
        end
    end

endmodule

// ==== src/axil_led_regs.sv ====
/* LED and ID registers on AXI-Lite. Only strobe bit 0 updates the LED byte;
   the ID word is read-only and a write to it answers SLVERR. */
`timescale 1ns/10ps

module axil_led_regs
    import axil_mem_pkg::*;
(
    input  logic             aclk,
    input  logic             aresetn,
    input  axil_req_t        req,
    output axil_rsp_t        rsp,
    output logic [LED_W-1:0] led
);

    logic              wr_take;
    logic              rd_take;
    logic              wr_is_id;
    logic              rd_is_id;
    logic              b_valid_q;
    logic [1:0]        b_resp_q;
    logic              r_valid_q;
    logic [DATA_W-1:0] r_data_q;
    logic [LED_W-1:0]  led_q;

    // Decoder has already matched the window, only the word select is left
    assign wr_is_id = req.aw_addr[3:2] == ID_OFFS[3:2];
    assign rd_is_id = req.ar_addr[3:2] == ID_OFFS[3:2];

    assign wr_take = req.aw_valid && req.w_valid && !b_valid_q;
    assign rd_take = req.ar_valid && !r_valid_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            led_q     <= '0;
            b_valid_q <= 1'b0;
        end else if (wr_take) begin
            b_valid_q <= 1'b1;
            if (!wr_is_id && req.w_strb[0]) begin
                led_q <= req.w_data[LED_W-1:0];
            end
        end else if (req.b_ready) begin
            b_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_take) begin
            b_resp_q <= wr_is_id ? RESP_SLVERR : RESP_OKAY;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            r_valid_q <= 1'b0;
        end else if (rd_take) begin
            r_valid_q <= 1'b1;
        end else if (req.r_ready) begin
            r_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_take) begin
            r_data_q <= rd_is_id ? ID_VALUE : DATA_W'(led_q);   // LED zero-extended
        end
    end

    always_comb begin
        rsp          = '0;
        rsp.aw_ready = wr_take;
        rsp.w_ready  = wr_take;
        rsp.b_valid  = b_valid_q;
        rsp.b_resp   = b_resp_q;
        rsp.ar_ready = rd_take;
        rsp.r_valid  = r_valid_q;
        rsp.r_data   = r_data_q;
        rsp.r_resp   = RESP_OKAY;
    end

    assign led = led_q;

endmodule

// ==== src/axil_mem_subsys.sv ====
/* AXI-Lite memory subsystem: 1 KiB RAM at RAM_BASE, LED and ID registers at REG_BASE.
   Write and read latency is one cycle each, one transaction per direction. */
`timescale 1ns/10ps

module axil_mem_subsys
    import axil_mem_pkg::*;
(
    input  logic             aclk,
    input  logic             aresetn,
    input  axil_req_t        s_req,
    output axil_rsp_t        s_rsp,
    output logic [LED_W-1:0] led
);

    axil_req_t ram_req;   // Decoder to RAM
    axil_rsp_t ram_rsp;
    axil_req_t reg_req;   // Decoder to register block
    axil_rsp_t reg_rsp;

    axil_addr_decoder u_decoder (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_req   (s_req),
        .s_rsp   (s_rsp),
        .ram_req (ram_req),
        .ram_rsp (ram_rsp),
        .reg_req (reg_req),
        .reg_rsp (reg_rsp)
    );

    axil_ram u_ram (
        .aclk    (aclk),
        .aresetn (aresetn),
        .req     (ram_req),
        .rsp     (ram_rsp)
    );

    axil_led_regs u_regs (
        .aclk    (aclk),
        .aresetn (aresetn),
        .req     (reg_req),
        .rsp     (reg_rsp),
        .led     (led)
    );

endmodule

// ==== sim/tb_clock.sv ====
/* Free-running 10 ns clock. aresetn is low for three cycles at start and again on each rst_req. */
`timescale 1ns/10ps

module tb_clock (
    input  logic rst_req,
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Reset edges fall on the negative clock edge
    initial begin
        aresetn = 1'b0;
        forever begin
            repeat (3) @(posedge aclk);
            @(negedge aclk);
            aresetn = 1'b1;
            do begin
                @(posedge aclk);
            end while (!rst_req);
            @(negedge aclk);
            aresetn = 1'b0;   // Mid-run reset
        end
    end

endmodule

// ==== sim/axil_mem_subsys_checker.sv ====
/* Protocol checks on the top-level AXI-Lite port, bound into the DUT.
   Expects one transaction per direction and a one-cycle response latency. */
`timescale 1ns/10ps

module axil_mem_subsys_checker
    import axil_mem_pkg::*;
(
    input logic      aclk,
    input logic      aresetn,
    input axil_req_t s_req,
    input axil_rsp_t s_rsp
);

    logic aw_take;
    logic ar_take;

    assign aw_take = s_req.aw_valid && s_rsp.aw_ready;
    assign ar_take = s_req.ar_valid && s_rsp.ar_ready;

    // Responses hold under back-pressure
    a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_rsp.b_valid && !s_req.b_ready |=> s_rsp.b_valid && $stable(s_rsp.b_resp))
        else $error("B response changed or dropped before b_ready");

    a_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_rsp.r_valid && !s_req.r_ready |=>
            s_rsp.r_valid && $stable(s_rsp.r_data) && $stable(s_rsp.r_resp))
        else $error("R response changed or dropped before r_ready");

    a_b_after_aw: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(s_rsp.b_valid) |-> $past(aw_take))
        else $error("b_valid rose without a write accepted one cycle before");

    a_aw_to_b: assert property (@(posedge aclk) disable iff (!aresetn)
        aw_take |=> s_rsp.b_valid)
        else $error("No b_valid one cycle after write acceptance");

    a_r_after_ar: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(s_rsp.r_valid) |-> $past(ar_take))
        else $error("r_valid rose without a read accepted one cycle before");

    a_ar_to_r: assert property (@(posedge aclk) disable iff (!aresetn)
        ar_take |=> s_rsp.r_valid)
        else $error("No r_valid one cycle after read acceptance");

    // One outstanding transaction per direction
    a_one_wr: assert property (@(posedge aclk) disable iff (!aresetn)
        s_rsp.b_valid |-> !s_rsp.aw_ready)
        else $error("Write address accepted while a B response is pending");

    a_one_rd: assert property (@(posedge aclk) disable iff (!aresetn)
        s_rsp.r_valid |-> !s_rsp.ar_ready)
        else $error("Read address accepted while an R response is pending");

endmodule

bind axil_mem_subsys axil_mem_subsys_checker u_checker (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_req   (s_req),
    .s_rsp   (s_rsp)
);

// ==== sim/axil_mem_subsys_tb.sv ====
/* Random-stimulus testbench for the AXI-Lite memory subsystem, seed 76.
   Inputs change on the falling edge; outputs are sampled 1 ns later. */
`timescale 1ns/10ps

module axil_mem_subsys_tb
    import axil_mem_pkg::*;
();

    localparam int N_RAND      = 200;
    localparam int N_BP        = 20;
    localparam int N_ERR       = 16;
    localparam int N_TXN       = 2 * RAM_WORDS + 2 * N_RAND + 2 * N_BP + 3 * N_ERR + 16;
    localparam int CYCLE_LIMIT = 2 * 9 * N_TXN;   // Up to 9 cycles per transaction

    logic              aclk;
    logic              aresetn;
    logic              rst_req;
    axil_req_t         s_req;
    axil_rsp_t         s_rsp;
    logic [LED_W-1:0]  led;
    logic [DATA_W-1:0] ram_model [RAM_WORDS];
    logic [STRB_W-1:0] written [RAM_WORDS];   // Bytes with a known value
    logic [LED_W-1:0]  led_model;
    int                checks;
    int                errors;
    int                test_errors;
    int                cycles = 0;
    int unsigned       idx;
    logic [31:0]       addr;
    logic [31:0]       data;
    logic [31:0]       rdata;
    logic [3:0]        strb;
    logic [1:0]        resp;

    tb_clock u_clk (
        .rst_req (rst_req),
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    axil_mem_subsys u_dut (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_req   (s_req),
        .s_rsp   (s_rsp),
        .led     (led)
    );

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %-14s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic write_txn(input logic [31:0] a, input logic [31:0] d, input logic [3:0] st,
                             input int hold, output logic [1:0] rsp_code);
        @(negedge aclk);
        s_req.aw_addr  = a;
        s_req.w_data   = d;
        s_req.w_strb   = st;
        s_req.aw_valid = 1'b1;
        s_req.w_valid  = 1'b1;
        s_req.b_ready  = (hold == 0);
        #1;
        while (!s_rsp.aw_ready) begin
            @(negedge aclk);
            #1;
        end
        check("w_ready", 32'd1, 32'(s_rsp.w_ready));   // Rises with aw_ready
        @(negedge aclk);
        s_req.aw_valid = 1'b0;
        s_req.w_valid  = 1'b0;
        #1;
        while (!s_rsp.b_valid) begin
            @(negedge aclk);
            #1;
        end
        rsp_code = s_rsp.b_resp;
        for (int i = 0; i < hold; i++) begin
            @(negedge aclk);
            s_req.aw_valid = 1'b1;   // Repeat request must not be taken while B waits
            s_req.w_valid  = 1'b1;
            #1;
            check("aw_ready", 32'd0, 32'(s_rsp.aw_ready));
            check("w_ready", 32'd0, 32'(s_rsp.w_ready));
            check("b_valid", 32'd1, 32'(s_rsp.b_valid));
            check("b_resp", 32'(rsp_code), 32'(s_rsp.b_resp));
        end
        @(negedge aclk);
        s_req.aw_valid = 1'b0;
        s_req.w_valid  = 1'b0;
        s_req.b_ready  = 1'b1;
        @(negedge aclk);
    endtask

    task automatic read_txn(input logic [31:0] a, input int hold,
                            output logic [31:0] d, output logic [1:0] rsp_code);
        @(negedge aclk);
        s_req.ar_addr  = a;
        s_req.ar_valid = 1'b1;
        s_req.r_ready  = (hold == 0);
        #1;
        while (!s_rsp.ar_ready) begin
            @(negedge aclk);
            #1;
        end
        @(negedge aclk);
        s_req.ar_valid = 1'b0;
        #1;
        while (!s_rsp.r_valid) begin
            @(negedge aclk);
            #1;
        end
        d        = s_rsp.r_data;
        rsp_code = s_rsp.r_resp;
        for (int i = 0; i < hold; i++) begin
            @(negedge aclk);
            s_req.ar_valid = 1'b1;
            #1;
            check("ar_ready", 32'd0, 32'(s_rsp.ar_ready));
            check("r_valid", 32'd1, 32'(s_rsp.r_valid));
            check("r_data", d, s_rsp.r_data);
        end
        @(negedge aclk);
        s_req.ar_valid = 1'b0;
        s_req.r_ready  = 1'b1;
        @(negedge aclk);
    endtask

    task automatic model_write(input int unsigned i, input logic [31:0] d, input logic [3:0] st);
        for (int b = 0; b < STRB_W; b++) begin
            if (st[b]) begin
                ram_model[i][b*8 +: 8] = d[b*8 +: 8];
            end
        end
        written[i] = written[i] | st;
    endtask

    // Reads one RAM word and compares only bytes the model knows
    task automatic read_ram_check(input int unsigned i, input int hold);
        logic [31:0] d;
        logic [31:0] mask;
        logic [1:0]  rc;
        read_txn(RAM_BASE + 32'(4 * i), hold, d, rc);
        for (int b = 0; b < STRB_W; b++) begin
            mask[b*8 +: 8] = {8{written[i][b]}};
        end
        check("r_data", ram_model[i] & mask, d & mask);
        check("r_resp", 32'(RESP_OKAY), 32'(rc));
    endtask

    function automatic logic unmapped(input logic [31:0] a);
        logic [31:0] word;
        word = {a[31:2], 2'b00};
        return ((a - RAM_BASE) >= RAM_BYTES) && (word != REG_BASE + LED_OFFS)
               && (word != REG_BASE + ID_OFFS);
    endfunction

    always @(posedge aclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        s_req       = '0;
        rst_req     = 1'b0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        led_model   = '0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            written[i] = '0;
        end
        void'($urandom(76));
        wait (aresetn === 1'b1);
        #1;
        check("b_valid", 32'd0, 32'(s_rsp.b_valid));
        check("r_valid", 32'd0, 32'(s_rsp.r_valid));
        check("led", 32'd0, 32'(led));
        s_req.b_ready = 1'b1;
        s_req.r_ready = 1'b1;
        end_test("reset");

        for (int unsigned i = 0; i < RAM_WORDS; i++) begin
            data = $urandom;
            write_txn(RAM_BASE + 32'(4 * i), data, 4'hF, 0, resp);
            check("b_resp", 32'(RESP_OKAY), 32'(resp));
            model_write(i, data, 4'hF);
        end
        for (int unsigned i = 0; i < RAM_WORDS; i++) begin
            read_ram_check(i, 0);
        end
        end_test("ram_fill");

        for (int i = 0; i < N_RAND; i++) begin
            idx  = $urandom_range(RAM_WORDS - 1);
            data = $urandom;
            strb = 4'($urandom);
            write_txn(RAM_BASE + 32'(4 * idx), data, strb, 0, resp);
            check("b_resp", 32'(RESP_OKAY), 32'(resp));
            model_write(idx, data, strb);
            if ($urandom_range(1) == 1) begin
                read_ram_check($urandom_range(RAM_WORDS - 1), 0);
            end
        end
        end_test("byte_strobes");

        data = $urandom;
        write_txn(REG_BASE + LED_OFFS, data, 4'(($urandom & 32'hE) | 32'h1), 0, resp);
        led_model = data[7:0];
        check("b_resp", 32'(RESP_OKAY), 32'(resp));
        check("led", 32'(led_model), 32'(led));
        write_txn(REG_BASE + LED_OFFS, ~data, 4'($urandom & 32'hE), 0, resp);   // Byte 0 off
        check("b_resp", 32'(RESP_OKAY), 32'(resp));
        check("led", 32'(led_model), 32'(led));
        read_txn(REG_BASE + LED_OFFS, 0, rdata, resp);
        check("r_data", {24'd0, led_model}, rdata);
        check("r_resp", 32'(RESP_OKAY), 32'(resp));
        read_txn(REG_BASE + ID_OFFS, 0, rdata, resp);
        check("r_data", ID_VALUE, rdata);
        check("r_resp", 32'(RESP_OKAY), 32'(resp));
        write_txn(REG_BASE + ID_OFFS, $urandom, 4'hF, 0, resp);
        check("b_resp", 32'(RESP_SLVERR), 32'(resp));
        read_txn(REG_BASE + ID_OFFS, 0, rdata, resp);
        check("r_data", ID_VALUE, rdata);
        check("r_resp", 32'(RESP_OKAY), 32'(resp));
        end_test("registers");

        for (int i = 0; i < N_ERR; i++) begin
            do begin
                addr = $urandom;
            end while (!unmapped(addr));
            write_txn(addr, $urandom, 4'hF, 0, resp);
            check("b_resp", 32'(RESP_DECERR), 32'(resp));
            read_txn(addr, 0, rdata, resp);
            check("r_data", 32'd0, rdata);
            check("r_resp", 32'(RESP_DECERR), 32'(resp));
            read_ram_check(addr[RAM_IDX_W+1:2], 0);   // Word the address would alias to
        end
        end_test("unmapped");

        for (int i = 0; i < N_BP; i++) begin
            idx  = $urandom_range(RAM_WORDS - 1);
            data = $urandom;
            write_txn(RAM_BASE + 32'(4 * idx), data, 4'hF, $urandom_range(5), resp);
            check("b_resp", 32'(RESP_OKAY), 32'(resp));
            model_write(idx, data, 4'hF);
            read_ram_check(idx, $urandom_range(5));
        end
        end_test("back_pressure");

        // Leave a B and an R response waiting so the reset has state to clear
        data = $urandom | 32'h1;
        @(negedge aclk);
        s_req.aw_addr  = REG_BASE + LED_OFFS;
        s_req.w_data   = data;
        s_req.w_strb   = 4'h1;
        s_req.aw_valid = 1'b1;
        s_req.w_valid  = 1'b1;
        s_req.b_ready  = 1'b0;
        s_req.ar_addr  = REG_BASE + ID_OFFS;
        s_req.ar_valid = 1'b1;
        s_req.r_ready  = 1'b0;
        @(negedge aclk);
        s_req.aw_valid = 1'b0;
        s_req.w_valid  = 1'b0;
        s_req.ar_valid = 1'b0;
        led_model      = data[7:0];
        #1;
        check("b_valid", 32'd1, 32'(s_rsp.b_valid));
        check("r_valid", 32'd1, 32'(s_rsp.r_valid));
        check("led", 32'(led_model), 32'(led));
        rst_req = 1'b1;
        wait (aresetn === 1'b0);
        rst_req = 1'b0;
        wait (aresetn === 1'b1);
        #1;
        led_model = '0;
        check("b_valid", 32'd0, 32'(s_rsp.b_valid));
        check("r_valid", 32'd0, 32'(s_rsp.r_valid));
        check("led", 32'd0, 32'(led));
        @(negedge aclk);
        s_req.b_ready = 1'b1;
        read_txn(REG_BASE + LED_OFFS, 0, rdata, resp);
        check("r_data", 32'd0, rdata);
        check("r_resp", 32'(RESP_OKAY), 32'(resp));
        read_ram_check($urandom_range(RAM_WORDS - 1), 0);   // RAM keeps its contents
        end_test("mid_reset");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== axil_mem_subsys.f ====
src/axil_mem_pkg.sv
src/axil_ram.sv
src/axil_addr_decoder.sv
src/axil_led_regs.sv
src/axil_mem_subsys.sv
sim/tb_clock.sv
sim/axil_mem_subsys_checker.sv
sim/axil_mem_subsys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f axil_mem_subsys.f \
    --top-module axil_mem_subsys_tb -Mdir obj_dir || exit 1

./obj_dir/Vaxil_mem_subsys_tb > sim.log 2>&1
cat sim.log

grep -qx "ALL CHECKS PASSED" sim.log && exit 0 || exit 1
